// File: src.f
hw/u3v_pkg.sv
hw/frame_sequencer.sv
hw/block_counter.sv
hw/payload_status.sv
hw/packet_mux.sv
hw/u3v_format.sv
bench/u3v_format_chk.sv
bench/tb_u3v_format.sv

// File: Makefile
# Verilator build and run of the frame formatter testbench

TOP := tb_u3v_format

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: bench/tb_u3v_format.sv
//--------------------------------------------------
// testbench of the frame formatter
// runs frames over the chunk settings, overrun and
// stream restart; checks every valid output word
//--------------------------------------------------
`timescale 1ns/1ps

module tb_u3v_format;

	logic            clk;
	logic            i_rst;
	logic            i_fval;
	logic            i_data_valid;
	u3v_pkg::data_t  i_data;
	logic            i_stream_enable;
	u3v_pkg::long_t  i_timestamp;
	u3v_pkg::reg_t   i_pixel_format;
	u3v_pkg::short_t i_size_x;
	u3v_pkg::short_t i_size_y;
	u3v_pkg::short_t i_offset_x;
	u3v_pkg::short_t i_offset_y;
	u3v_pkg::reg_t   i_trailer_size_y;
	u3v_pkg::reg_t   i_chunk_size_img;
	logic            i_chunk_mode;
	logic            i_chunk_ts_en;
	logic            i_chunk_fid_en;
	logic            o_fval;
	logic            o_data_valid;
	u3v_pkg::data_t  o_data;

	// lfsr state, image words sent, expected and received words
	logic [31:0]     lfsr;
	u3v_pkg::data_t  img_q[$];
	u3v_pkg::data_t  exp_q[$];
	u3v_pkg::data_t  rx_q[$];
	u3v_pkg::long_t  exp_block;
	logic [7:0]      exp_layout;
	int              frames_checked;
	int              head_cycles;
	int              tail_cycles;
	logic            fval_prev;
	string           test_name;

	u3v_format dut (
		.clk              (clk),
		.i_rst            (i_rst),
		.i_fval           (i_fval),
		.i_data_valid     (i_data_valid),
		.i_data           (i_data),
		.i_stream_enable  (i_stream_enable),
		.i_timestamp      (i_timestamp),
		.i_pixel_format   (i_pixel_format),
		.i_size_x         (i_size_x),
		.i_size_y         (i_size_y),
		.i_offset_x       (i_offset_x),
		.i_offset_y       (i_offset_y),
		.i_trailer_size_y (i_trailer_size_y),
		.i_chunk_size_img (i_chunk_size_img),
		.i_chunk_mode     (i_chunk_mode),
		.i_chunk_ts_en    (i_chunk_ts_en),
		.i_chunk_fid_en   (i_chunk_fid_en),
		.o_fval           (o_fval),
		.o_data_valid     (o_data_valid),
		.o_data           (o_data)
	);

	// 40 ns clock
	always #20 clk = ~clk;

	//--------------------------------------------------
	// helpers
	//--------------------------------------------------
	// fibonacci lfsr with taps 32 22 2 1 and one step per bit
	function automatic u3v_pkg::data_t take_bits(input int n);
		u3v_pkg::data_t v;
		logic           fb;
		int             k;
		v = '0;
		for (k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[62:0], fb};
		end
		return v;
	endfunction

	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "testbench stopped on first error");
	endtask

	task automatic check_word(input string name, input int idx,
			input u3v_pkg::data_t exp, input u3v_pkg::data_t act);
		if (exp !== act) begin
			$display("Fail %s word %0d: expected %h, actual %h", name, idx, exp, act);
			fail_stop("output word mismatch");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
			fail_stop("count mismatch");
		end
	endtask

	task automatic check_fval(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			fail_stop("frame valid mismatch");
		end
	endtask

	//--------------------------------------------------
	// reference model
	//--------------------------------------------------
	// expected valid words of one frame from the current config
	function automatic void build_expected(input u3v_pkg::long_t blk, input logic [7:0] layout);
		u3v_pkg::reg_t   bytes;
		u3v_pkg::reg_t   vsize;
		u3v_pkg::short_t status;
		logic [15:0]     ptype;
		logic [15:0]     tsize;
		exp_q.delete();
		ptype = i_chunk_mode ? 16'h4001 : 16'h0001;
		tsize = i_chunk_mode ? 16'd36 : 16'd32;
		// leader key is ascii U3VL with the first char in the low byte
		exp_q.push_back({16'd52, 16'd0, 32'h4c56_3355});
		exp_q.push_back(blk);
		exp_q.push_back({i_timestamp[31:0], ptype, 16'd0});
		exp_q.push_back({i_pixel_format, i_timestamp[63:32]});
		exp_q.push_back({16'd0, i_size_y, 16'd0, i_size_x});
		exp_q.push_back({16'd0, i_offset_y, 16'd0, i_offset_x});
		exp_q.push_back(64'd0);
		foreach (img_q[k]) begin
			exp_q.push_back(img_q[k]);
		end
		// chunks
		if (i_chunk_mode) begin
			exp_q.push_back({i_chunk_size_img, 32'd1});
		end
		if (i_chunk_mode && i_chunk_fid_en) begin
			exp_q.push_back(blk);
			exp_q.push_back({32'd8, 32'd2});
		end
		if (i_chunk_mode && i_chunk_ts_en) begin
			exp_q.push_back(i_timestamp);
			exp_q.push_back({32'd8, 32'd3});
		end
		// payload size with whole words compared
		bytes = u3v_pkg::reg_t'(img_q.size()) << 3;
		if (bytes[31:3] > i_chunk_size_img[31:3]) begin
			status = 16'ha101;
			vsize = i_chunk_size_img;
		end else begin
			status = 16'h0000;
			vsize = bytes;
		end
		if (i_chunk_mode) begin
			vsize = vsize + 32'd8 + (i_chunk_ts_en ? 32'd16 : 32'd0) +
				(i_chunk_fid_en ? 32'd16 : 32'd0);
		end
		// trailer key is ascii U3VT
		exp_q.push_back(64'd0);
		exp_q.push_back({tsize, 16'd0, 32'h5456_3355});
		exp_q.push_back(blk);
		exp_q.push_back({vsize, 16'd0, status});
		exp_q.push_back({i_trailer_size_y, 32'd0});
		exp_q.push_back({56'd0, layout});
		exp_q.push_back(64'd0);
	endfunction

	task automatic check_frame();
		build_expected(exp_block, exp_layout);
		check_count({test_name, " ts wait"}, u3v_pkg::TS_WAIT, head_cycles);
		check_count({test_name, " extension"}, u3v_pkg::EXT_CYCLES, tail_cycles);
		check_count({test_name, " word count"}, exp_q.size(), rx_q.size());
		foreach (exp_q[k]) begin
			check_word(test_name, k, exp_q[k], rx_q[k]);
		end
	endtask

	//--------------------------------------------------
	// compare process
	//--------------------------------------------------
	// samples at the falling edge away from any output change
	always @(negedge clk) begin
		if (!i_rst) begin
			if (o_data_valid) begin
				rx_q.push_back(o_data);
				tail_cycles = 0;
			end else if (o_fval) begin
				if (rx_q.size() == 0) begin
					head_cycles++;
				end
				tail_cycles++;
			end
			// end of frame
			if (fval_prev && !o_fval) begin
				check_frame();
				rx_q.delete();
				head_cycles = 0;
				tail_cycles = 0;
				frames_checked++;
			end
			fval_prev = o_fval;
		end
	end

	//--------------------------------------------------
	// stimulus
	//--------------------------------------------------
	task automatic set_chunks(input logic cm, input logic ts, input logic fid);
		if ({cm, ts, fid} != {i_chunk_mode, i_chunk_ts_en, i_chunk_fid_en}) begin
			exp_layout = exp_layout + 8'd1;
		end
		i_chunk_mode = cm;
		i_chunk_ts_en = ts;
		i_chunk_fid_en = fid;
		@(posedge clk);
		#2;
	endtask

	task automatic run_frame(input string name, input int n_words);
		int sent;
		int t;
		int done_before;
		test_name = name;
		done_before = frames_checked;
		img_q.delete();
		i_timestamp = take_bits(64);
		i_pixel_format = u3v_pkg::reg_t'(take_bits(32));
		i_size_x = u3v_pkg::short_t'(take_bits(16));
		i_size_y = u3v_pkg::short_t'(take_bits(16));
		i_offset_x = u3v_pkg::short_t'(take_bits(16));
		i_offset_y = u3v_pkg::short_t'(take_bits(16));
		i_trailer_size_y = u3v_pkg::reg_t'(take_bits(32));
		i_fval = 1'b1;
		// image may start once the whole leader is out
		t = 0;
		while (rx_q.size() < u3v_pkg::LEADER_WORDS) begin
			@(posedge clk);
			#2;
			t++;
			if (t > 100) begin
				fail_stop("timeout waiting for the leader");
			end
		end
		check_fval({name, " fval in frame"}, 1'b1, o_fval);
		// image with random gaps
		sent = 0;
		while (sent < n_words) begin
			if (take_bits(2) == '0) begin
				i_data_valid = 1'b0;
			end else begin
				i_data = take_bits(64);
				i_data_valid = 1'b1;
				img_q.push_back(i_data);
				sent++;
			end
			@(posedge clk);
			#2;
		end
		i_data_valid = 1'b0;
		i_fval = 1'b0;
		t = 0;
		while (frames_checked == done_before) begin
			@(posedge clk);
			#2;
			t++;
			if (t > 200) begin
				fail_stop("timeout waiting for the end of the frame");
			end
		end
		exp_block = exp_block + 64'd1;
		// idle gap between frames with the output quiet
		repeat (30) begin
			@(posedge clk);
			#2;
			check_fval({name, " fval between frames"}, 1'b0, o_fval);
		end
	endtask

	initial begin
		clk = 1'b0;
		i_rst = 1'b1;
		i_fval = 1'b0;
		i_data_valid = 1'b0;
		i_data = '0;
		i_stream_enable = 1'b1;
		i_timestamp = '0;
		i_pixel_format = '0;
		i_size_x = '0;
		i_size_y = '0;
		i_offset_x = '0;
		i_offset_y = '0;
		i_trailer_size_y = '0;
		i_chunk_size_img = 32'd1024;
		i_chunk_mode = 1'b1;
		i_chunk_ts_en = 1'b1;
		i_chunk_fid_en = 1'b1;
		lfsr = 32'hcbf7;
		exp_block = '0;
		exp_layout = '0;
		frames_checked = 0;
		head_cycles = 0;
		tail_cycles = 0;
		fval_prev = 1'b0;
		test_name = "reset";
		repeat (10) @(posedge clk);
		#2;
		i_rst = 1'b0;
		check_fval("reset fval", 1'b0, o_fval);
		check_fval("reset data valid", 1'b0, o_data_valid);
		repeat (5) @(posedge clk);
		#2;

		// chunk combinations with block ids 0 to 4
		run_frame("chunk all", 20);
		set_chunks(1'b1, 1'b1, 1'b0);
		run_frame("chunk ts", 16);
		set_chunks(1'b1, 1'b0, 1'b1);
		run_frame("chunk fid", 12);
		set_chunks(1'b1, 1'b0, 1'b0);
		run_frame("chunk image only", 9);
		set_chunks(1'b0, 1'b0, 1'b0);
		run_frame("chunk off", 25);

		// longer than the configured size after two more layout steps
		set_chunks(1'b0, 1'b1, 1'b0);
		set_chunks(1'b1, 1'b1, 1'b1);
		i_chunk_size_img = 32'd100;
		run_frame("overrun", 20);
		i_chunk_size_img = 32'd1024;
		run_frame("no overrun", 3);

		// ids count from 0 again after a stream restart
		i_stream_enable = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		i_stream_enable = 1'b1;
		exp_block = '0;
		run_frame("restart first", 10);
		run_frame("restart second", 14);

		$display("sim passed");
		$finish;
	end

endmodule

// File: bench/u3v_format_chk.sv
//--------------------------------------------------
// protocol checks on the formatter outputs
// bound into every u3v_format instance
//--------------------------------------------------
`timescale 1ns/1ps

module u3v_format_chk (
	input logic clk,
	input logic i_rst,
	input logic i_out_fval,
	input logic i_out_valid
);

	// consecutive cycles with fval high
	logic [15:0] hi_len;

	always_ff @(posedge clk) begin
		if (i_rst || !i_out_fval) begin
			hi_len <= '0;
		end else begin
			hi_len <= hi_len + 16'd1;
		end
	end

	// no word outside a frame
	a_valid_in_fval: assert property (@(posedge clk) disable iff (i_rst)
		i_out_valid |-> i_out_fval)
		else $error("data valid without frame valid");

	// outputs quiet while held in reset
	a_reset_quiet: assert property (@(posedge clk)
		i_rst |=> (!i_out_fval && !i_out_valid))
		else $error("outputs active during reset");

	// a frame carries at least a leader and a trailer
	a_fval_len: assert property (@(posedge clk) disable iff (i_rst)
		$fell(i_out_fval) |->
		(hi_len >= 16'(u3v_pkg::LEADER_WORDS + u3v_pkg::TRAILER_WORDS)))
		else $error("frame valid pulse too short");

endmodule

bind u3v_format u3v_format_chk chk (
	.clk         (clk),
	.i_rst       (i_rst),
	.i_out_fval  (o_fval),
	.i_out_valid (o_data_valid)
);

// File: hw/u3v_format.sv
//--------------------------------------------------
// USB3 Vision frame formatter top level
// wraps a 64-bit pixel stream in leader, chunk and
// trailer words; free running, no back-pressure
//--------------------------------------------------
`timescale 1ns/1ps

module u3v_format (
	input  logic              clk,
	input  logic              i_rst,
	// input stream
	input  logic              i_fval,
	input  logic              i_data_valid,
	input  u3v_pkg::data_t    i_data,
	// configuration
	input  logic              i_stream_enable,
	input  u3v_pkg::long_t    i_timestamp,
	input  u3v_pkg::reg_t     i_pixel_format,
	input  u3v_pkg::short_t   i_size_x,
	input  u3v_pkg::short_t   i_size_y,
	input  u3v_pkg::short_t   i_offset_x,
	input  u3v_pkg::short_t   i_offset_y,
	input  u3v_pkg::reg_t     i_trailer_size_y,
	input  u3v_pkg::reg_t     i_chunk_size_img,
	input  logic              i_chunk_mode,
	input  logic              i_chunk_ts_en,
	input  logic              i_chunk_fid_en,
	// formatted stream
	output logic              o_fval,
	output logic              o_data_valid,
	output u3v_pkg::data_t    o_data
);

	u3v_pkg::state_t state;
	u3v_pkg::cnt_t   word_cnt;
	logic            fval_rise;
	logic            fval_fall;
	logic            stream_on;
	logic            ext_last;
	u3v_pkg::long_t  sum;
	u3v_pkg::long_t  block_id;
	u3v_pkg::reg_t   valid_size;
	u3v_pkg::short_t status;
	logic [7:0]      layout_id;

	//--------------------------------------------------
	// control
	//--------------------------------------------------
	frame_sequencer u_seq (
		.clk             (clk),
		.i_rst           (i_rst),
		.i_fval          (i_fval),
		.i_stream_enable (i_stream_enable),
		.o_state         (state),
		.o_word_cnt      (word_cnt),
		.o_fval_rise     (fval_rise),
		.o_fval_fall     (fval_fall),
		.o_stream_on     (stream_on),
		.o_ext_last      (ext_last)
	);

	block_counter u_cnt (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_state      (state),
		.i_data_valid (i_data_valid),
		.i_fval_rise  (fval_rise),
		.i_stream_on  (stream_on),
		.i_ext_last   (ext_last),
		.o_sum        (sum),
		.o_block_id   (block_id)
	);

	payload_status u_status (
		.clk              (clk),
		.i_rst            (i_rst),
		.i_fval_rise      (fval_rise),
		.i_fval_fall      (fval_fall),
		.i_sum            (sum),
		.i_chunk_size_img (i_chunk_size_img),
		.i_chunk_mode     (i_chunk_mode),
		.i_chunk_ts_en    (i_chunk_ts_en),
		.i_chunk_fid_en   (i_chunk_fid_en),
		.o_valid_size     (valid_size),
		.o_status         (status),
		.o_layout_id      (layout_id)
	);

	//--------------------------------------------------
	// output words
	//--------------------------------------------------
	packet_mux u_mux (
		.clk              (clk),
		.i_rst            (i_rst),
		.i_state          (state),
		.i_word_cnt       (word_cnt),
		.i_data           (i_data),
		.i_data_valid     (i_data_valid),
		.i_block_id       (block_id),
		.i_valid_size     (valid_size),
		.i_status         (status),
		.i_layout_id      (layout_id),
		.i_timestamp      (i_timestamp),
		.i_pixel_format   (i_pixel_format),
		.i_size_x         (i_size_x),
		.i_size_y         (i_size_y),
		.i_offset_x       (i_offset_x),
		.i_offset_y       (i_offset_y),
		.i_trailer_size_y (i_trailer_size_y),
		.i_chunk_size_img (i_chunk_size_img),
		.i_chunk_mode     (i_chunk_mode),
		.i_chunk_ts_en    (i_chunk_ts_en),
		.i_chunk_fid_en   (i_chunk_fid_en),
		.o_data           (o_data),
		.o_data_valid     (o_data_valid),
		.o_fval           (o_fval)
	);

endmodule

// File: hw/packet_mux.sv
//--------------------------------------------------
// output word builder
// picks leader, image, chunk or trailer word per
// state and count; all outputs one cycle late
//--------------------------------------------------
`timescale 1ns/1ps

module packet_mux (
	input  logic              clk,
	input  logic              i_rst,
	input  u3v_pkg::state_t   i_state,
	input  u3v_pkg::cnt_t     i_word_cnt,
	input  u3v_pkg::data_t    i_data,
	input  logic              i_data_valid,
	input  u3v_pkg::long_t    i_block_id,
	input  u3v_pkg::reg_t     i_valid_size,
	input  u3v_pkg::short_t   i_status,
	input  logic [7:0]        i_layout_id,
	input  u3v_pkg::long_t    i_timestamp,
	input  u3v_pkg::reg_t     i_pixel_format,
	input  u3v_pkg::short_t   i_size_x,
	input  u3v_pkg::short_t   i_size_y,
	input  u3v_pkg::short_t   i_offset_x,
	input  u3v_pkg::short_t   i_offset_y,
	input  u3v_pkg::reg_t     i_trailer_size_y,
	input  u3v_pkg::reg_t     i_chunk_size_img,
	input  logic              i_chunk_mode,
	input  logic              i_chunk_ts_en,
	input  logic              i_chunk_fid_en,
	output u3v_pkg::data_t    o_data,
	output logic              o_data_valid,
	output logic              o_fval
);

	//--------------------------------------------------
	// data word
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		case (i_state)
			u3v_pkg::S_LEADER: begin
				case (i_word_cnt)
					// leader size 52 bytes
					4'd0: o_data <= {16'd52, 16'd0, u3v_pkg::LEADER_KEY};
					4'd1: o_data <= i_block_id;
					// payload type 0x0001 for image or 0x4001 for image with chunk
					4'd2: o_data <= {i_timestamp[31:0], 1'b0, i_chunk_mode, 14'h0001, 16'h0000};
					4'd3: o_data <= {i_pixel_format, i_timestamp[63:32]};
					4'd4: o_data <= {16'h0000, i_size_y, 16'h0000, i_size_x};
					4'd5: o_data <= {16'h0000, i_offset_y, 16'h0000, i_offset_x};
					default: o_data <= '0;
				endcase
			end
			u3v_pkg::S_CHUNK: begin
				// first chunk word comes after the settle wait
				// {length, id} pairs trail each chunk body
				case (i_word_cnt - u3v_pkg::cnt_t'(u3v_pkg::TS_WAIT))
					4'd0: o_data <= {i_chunk_size_img, 32'd1};
					4'd1: o_data <= i_block_id;
					4'd2: o_data <= {32'd8, 32'd2};
					4'd3: o_data <= i_timestamp;
					4'd4: o_data <= {32'd8, 32'd3};
					default: o_data <= '0;
				endcase
			end
			u3v_pkg::S_TRAILER: begin
				case (i_word_cnt)
					// trailer size 32 or 36 with chunk
					4'd1: o_data <= {13'h4, i_chunk_mode, 2'b00, 16'd0, u3v_pkg::TRAILER_KEY};
					4'd2: o_data <= i_block_id;
					4'd3: o_data <= {i_valid_size, 16'h0000, i_status};
					4'd4: o_data <= {i_trailer_size_y, 32'h0};
					4'd5: o_data <= {32'h0, 24'h0, i_layout_id};
					// words 0 and 6 are padding
					default: o_data <= '0;
				endcase
			end
			// image passes through
			default: o_data <= i_data;
		endcase
	end

	//--------------------------------------------------
	// valid and fval
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_data_valid <= 1'b0;
		end else begin
			case (i_state)
				u3v_pkg::S_LEADER, u3v_pkg::S_TRAILER: o_data_valid <= 1'b1;
				u3v_pkg::S_IMAGE: o_data_valid <= i_data_valid;
				u3v_pkg::S_CHUNK: begin
					// each chunk only when enabled
					case (i_word_cnt - u3v_pkg::cnt_t'(u3v_pkg::TS_WAIT))
						4'd0:       o_data_valid <= i_chunk_mode;
						4'd1, 4'd2: o_data_valid <= i_chunk_mode & i_chunk_fid_en;
						4'd3, 4'd4: o_data_valid <= i_chunk_mode & i_chunk_ts_en;
						default:    o_data_valid <= 1'b0;
					endcase
				end
				default: o_data_valid <= 1'b0;
			endcase
		end
	end

	// high from ts wait through ext and low in idle
	always_ff @(posedge clk) begin
		if (i_rst || i_state == u3v_pkg::S_IDLE) begin
			o_fval <= 1'b0;
		end else if (i_state == u3v_pkg::S_TS_WAIT) begin
			o_fval <= 1'b1;
		end
	end

endmodule

// File: hw/payload_status.sv
//--------------------------------------------------
// trailer status fields of a frame
// byte count at fval fall, overrun code, valid
// payload size and the chunk layout id
//--------------------------------------------------
`timescale 1ns/1ps

module payload_status (
	input  logic             clk,
	input  logic             i_rst,
	input  logic             i_fval_rise,
	input  logic             i_fval_fall,
	input  u3v_pkg::long_t   i_sum,
	input  u3v_pkg::reg_t    i_chunk_size_img,
	input  logic             i_chunk_mode,
	input  logic             i_chunk_ts_en,
	input  logic             i_chunk_fid_en,
	output u3v_pkg::reg_t    o_valid_size,
	output u3v_pkg::short_t  o_status,
	output logic [7:0]       o_layout_id
);

	u3v_pkg::reg_t byte_cnt;
	u3v_pkg::reg_t clamp_size;
	logic          overrun;
	logic [2:0]    en_q;
	logic [7:0]    layout_id;

	//--------------------------------------------------
	// byte count and size
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_fval_rise) begin
			byte_cnt <= '0;
		end else if (i_fval_fall) begin
			// words to bytes
			byte_cnt <= u3v_pkg::reg_t'(i_sum << u3v_pkg::BYTE_SHIFT);
		end
	end

	// whole words only, low 3 bits ignored
	assign overrun    = byte_cnt[31:3] > i_chunk_size_img[31:3];
	assign clamp_size = overrun ? i_chunk_size_img : byte_cnt;

	always_ff @(posedge clk) begin
		o_status <= overrun ? u3v_pkg::OVERRUN_STATUS : 16'h0000;
		// chunk overhead: 8 for image chunk, 16 per extra chunk
		case ({i_chunk_mode, i_chunk_ts_en, i_chunk_fid_en})
			3'b100:         o_valid_size <= clamp_size + 32'd8;
			3'b110, 3'b101: o_valid_size <= clamp_size + 32'd24;
			3'b111:         o_valid_size <= clamp_size + 32'd40;
			default:        o_valid_size <= clamp_size;
		endcase
	end

	//--------------------------------------------------
	// chunk layout id
	//--------------------------------------------------
	// follows inputs in reset so no step at release
	always_ff @(posedge clk) begin
		if (i_rst) begin
			en_q      <= {i_chunk_mode, i_chunk_ts_en, i_chunk_fid_en};
			layout_id <= '0;
		end else begin
			en_q <= {i_chunk_mode, i_chunk_ts_en, i_chunk_fid_en};
			// any enable toggled
			if (en_q != {i_chunk_mode, i_chunk_ts_en, i_chunk_fid_en}) begin
				layout_id <= layout_id + 8'd1;
			end
		end
	end

	assign o_layout_id = layout_id;

endmodule

// File: hw/block_counter.sv
//--------------------------------------------------
// one 47-bit accumulator shared by two jobs
// counts image words inside a frame, steps the
// block id at the end of the frame extension
//--------------------------------------------------
`timescale 1ns/1ps

module block_counter (
	input  logic              clk,
	input  logic              i_rst,
	input  u3v_pkg::state_t   i_state,
	input  logic              i_data_valid,
	input  logic              i_fval_rise,
	input  logic              i_stream_on,
	input  logic              i_ext_last,
	output u3v_pkg::long_t    o_sum,
	output u3v_pkg::long_t    o_block_id
);

	logic [46:0] acc;
	logic [46:0] block_id;
	logic [46:0] acc_base;
	logic        acc_en;

	// image words, or one id step on the last ext cycle
	assign acc_en = (i_state == u3v_pkg::S_IMAGE && i_data_valid) || i_ext_last;
	// ext adds to the held id, image adds to itself
	assign acc_base = i_ext_last ? block_id : acc;

	//--------------------------------------------------
	// accumulator
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_rst || !i_stream_on || i_fval_rise) begin
			// fresh count each frame
			acc <= '0;
		end else if (acc_en) begin
			acc <= acc_base + 47'd1;
		end
	end

	// idle copies id+1 in; stream off restarts at 0
	always_ff @(posedge clk) begin
		if (i_rst || !i_stream_on) begin
			block_id <= '0;
		end else if (i_state == u3v_pkg::S_IDLE) begin
			block_id <= acc;
		end
	end

	assign o_sum      = {17'd0, acc};
	assign o_block_id = {17'd0, block_id};

endmodule

// File: hw/frame_sequencer.sv
//--------------------------------------------------
// frame state machine of the formatter
// steps idle / ts wait / leader / image / chunk /
// trailer / extension and counts words per section
//--------------------------------------------------
`timescale 1ns/1ps

module frame_sequencer (
	input  logic              clk,
	input  logic              i_rst,
	input  logic              i_fval,
	input  logic              i_stream_enable,
	output u3v_pkg::state_t   o_state,
	output u3v_pkg::cnt_t     o_word_cnt,
	output logic              o_fval_rise,
	output logic              o_fval_fall,
	output logic              o_stream_on,
	output logic              o_ext_last
);

	u3v_pkg::state_t state;
	u3v_pkg::state_t state_nxt;
	u3v_pkg::cnt_t   word_cnt;
	logic [3:0]      ext_cnt;
	logic            fval_q;
	logic            fval_qq;
	logic            stream_on;
	logic            sec_last;

	//--------------------------------------------------
	// fval edges
	//--------------------------------------------------
	// two stages so the edge shows one cycle after sampling
	always_ff @(posedge clk) begin
		if (i_rst) begin
			fval_q  <= 1'b0;
			fval_qq <= 1'b0;
		end else begin
			fval_q  <= i_fval;
			fval_qq <= fval_q;
		end
	end

	assign o_fval_rise = fval_q & ~fval_qq;
	assign o_fval_fall = ~fval_q & fval_qq;

	// stream enable takes effect only at a frame start
	always_ff @(posedge clk) begin
		if (i_rst || !i_stream_enable) begin
			stream_on <= 1'b0;
		end else if (o_fval_rise) begin
			stream_on <= 1'b1;
		end
	end

	//--------------------------------------------------
	// section counters
	//--------------------------------------------------
	// last word of the current fixed-length section
	always_comb begin
		case (state)
			u3v_pkg::S_TS_WAIT:
				sec_last = (word_cnt == u3v_pkg::cnt_t'(u3v_pkg::TS_WAIT - 1));
			u3v_pkg::S_LEADER:
				sec_last = (word_cnt == u3v_pkg::cnt_t'(u3v_pkg::LEADER_WORDS - 1));
			u3v_pkg::S_CHUNK:
				sec_last = (word_cnt == u3v_pkg::cnt_t'(u3v_pkg::CHUNK_WORDS - 1));
			u3v_pkg::S_TRAILER:
				sec_last = (word_cnt == u3v_pkg::cnt_t'(u3v_pkg::TRAILER_WORDS - 1));
			default:
				sec_last = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			word_cnt <= '0;
		end else if (state == u3v_pkg::S_TS_WAIT || state == u3v_pkg::S_LEADER ||
				state == u3v_pkg::S_CHUNK || state == u3v_pkg::S_TRAILER) begin
			// wraps at each section size
			word_cnt <= sec_last ? '0 : word_cnt + 1'b1;
		end else begin
			word_cnt <= '0;
		end
	end

	// extension length
	always_ff @(posedge clk) begin
		if (i_rst || state != u3v_pkg::S_EXT) begin
			ext_cnt <= '0;
		end else begin
			ext_cnt <= ext_cnt + 1'b1;
		end
	end

	assign o_ext_last = (state == u3v_pkg::S_EXT) &&
		(ext_cnt == 4'(u3v_pkg::EXT_CYCLES - 1));

	//--------------------------------------------------
	// FSM
	//--------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			u3v_pkg::S_IDLE:    if (o_fval_rise) state_nxt = u3v_pkg::S_TS_WAIT;
			u3v_pkg::S_TS_WAIT: if (sec_last) state_nxt = u3v_pkg::S_LEADER;
			u3v_pkg::S_LEADER:  if (sec_last) state_nxt = u3v_pkg::S_IMAGE;
			// image runs until input fval drops
			u3v_pkg::S_IMAGE:   if (o_fval_fall) state_nxt = u3v_pkg::S_CHUNK;
			u3v_pkg::S_CHUNK:   if (sec_last) state_nxt = u3v_pkg::S_TRAILER;
			u3v_pkg::S_TRAILER: if (sec_last) state_nxt = u3v_pkg::S_EXT;
			u3v_pkg::S_EXT:     if (o_ext_last) state_nxt = u3v_pkg::S_IDLE;
			default:            state_nxt = u3v_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= u3v_pkg::S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign o_state     = state;
	assign o_word_cnt  = word_cnt;
	assign o_stream_on = stream_on;

endmodule

// File: hw/u3v_pkg.sv
//--------------------------------------------------
// shared types and constants of the USB3 Vision
// frame formatter; every RTL file refers to them
// through scoped names
//--------------------------------------------------

package u3v_pkg;

	//--------------------------------------------------
	// field types
	//--------------------------------------------------
	// one stream word
	typedef logic [63:0] data_t;
	// 32-bit register field
	typedef logic [31:0] reg_t;
	// size / offset field
	typedef logic [15:0] short_t;
	// timestamp and block id
	typedef logic [63:0] long_t;
	// section word counter, must hold CHUNK_WORDS-1
	typedef logic [3:0] cnt_t;

	// frame states, in stream order
	typedef enum logic [2:0] {
		S_IDLE    = 3'd0,
		S_TS_WAIT = 3'd1,
		S_LEADER  = 3'd2,
		S_IMAGE   = 3'd3,
		S_CHUNK   = 3'd4,
		S_TRAILER = 3'd5,
		S_EXT     = 3'd6
	} state_t;

	//--------------------------------------------------
	// timing
	//--------------------------------------------------
	// pixel clock in kHz
	localparam int CLK_FREQ_KHZ = 65000;
	// timestamp valid this long after fval rise
	localparam int TS_STABLE_NS = 95;
	// whole ns per clock, rounded down
	localparam int CLK_PERIOD_NS = 1000000 / CLK_FREQ_KHZ;
	// settle wait in cycles, one spare for the truncation
	localparam int TS_WAIT = TS_STABLE_NS / CLK_PERIOD_NS + 1;

	//--------------------------------------------------
	// section sizes
	//--------------------------------------------------
	localparam int LEADER_WORDS  = 7;
	localparam int TRAILER_WORDS = 7;
	// chunk state repeats the settle wait so the timestamp is stable again
	localparam int CHUNK_WORDS   = TS_WAIT + 5;
	// fval held after the last trailer word
	localparam int EXT_CYCLES    = 10;
	// 8 bytes per 64-bit word
	localparam int BYTE_SHIFT    = 3;

	//--------------------------------------------------
	// protocol codes
	//--------------------------------------------------
	// "U3VL" / "U3VT" in wire byte order, first char in the low byte
	localparam reg_t   LEADER_KEY     = 32'h4c56_3355;
	localparam reg_t   TRAILER_KEY    = 32'h5456_3355;
	localparam short_t OVERRUN_STATUS = 16'ha101;

endpackage
